/* compile.f */
hdl/core_pkg.sv
hdl/stage_if.sv
hdl/fetch.sv
hdl/decode.sv
hdl/rv32i_reg.sv
hdl/exec.sv
hdl/mem_access.sv
hdl/core.sv
sim/tb_core.sv

/* Makefile */
TOP := tb_core

all: run

run:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

/* sim/tb_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core;
    import core_pkg::*;

    localparam int PROG_LEN = 48;
    localparam int TIMEOUT  = 20 * PROG_LEN * 8;

    logic  clk;
    logic  rst_n;
    logic  inst_rden;
    word_t inst_riaddr;
    word_t inst_roaddr;
    logic  inst_rvalid;
    word_t inst_rdata;
    logic  data_rden;
    word_t data_riaddr;
    word_t data_roaddr;
    logic  data_rvalid;
    word_t data_rdata;
    logic  data_wren;
    word_t data_waddr;
    word_t data_wdata;
    logic  mem_wait;

    word_t prog [64];
    word_t dmem [64];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t exp_a;
    word_t exp_d;
    word_t i_addr;
    word_t d_addr;
    logic  i_busy;
    logic  d_busy;
    int    i_delay;
    int    d_delay;
    int    seed = 42;
    int    errors;
    int    checked;
    int    cycles;

    core u_core (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
    end

    function automatic word_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
    endfunction

    function automatic word_t enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic word_t enc_s(int off, int rs2, int rs1);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], OP_STORE};
    endfunction

    function automatic word_t enc_b(int off, int rs2, int rs1, int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t enc_u(int imm, int rd, logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic word_t enc_j(int off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL};
    endfunction

    // every data word differs, so a wrong load address shows up
    function automatic word_t fill_word(word_t addr);
        return (addr * 32'h9e37_79b9) ^ 32'h0bad_f00d;
    endfunction

    function automatic void load_program();
        for (int i = 0; i < 64; i++) begin
            prog[i] = 32'h0000_0013;
        end
        prog[0]  = enc_i(32'h123, 0, 0, 1, OP_IMM);
        prog[1]  = enc_i(-5, 0, 0, 2, OP_IMM);
        // dependent pairs right behind each other
        prog[2]  = enc_r(0, 2, 1, 0, 3);
        prog[3]  = enc_r(32'h20, 1, 3, 0, 4);
        prog[4]  = enc_s(0, 3, 0);
        prog[5]  = enc_s(4, 4, 0);
        prog[6]  = enc_i(3, 2, 1, 5, OP_IMM);
        prog[7]  = enc_i(32'h401, 2, 5, 6, OP_IMM);
        prog[8]  = enc_r(0, 1, 2, 5, 7);
        prog[9]  = enc_r(0, 1, 2, 2, 8);
        prog[10] = enc_r(0, 1, 2, 3, 9);
        prog[11] = enc_r(0, 2, 1, 4, 10);
        prog[12] = enc_i(32'h0f0, 1, 6, 11, OP_IMM);
        prog[13] = enc_r(0, 11, 10, 7, 12);
        prog[14] = enc_u(32'habcde, 13, OP_LUI);
        prog[15] = enc_u(1, 14, OP_AUIPC);
        prog[16] = enc_s(8, 5, 0);
        prog[17] = enc_s(12, 6, 0);
        prog[18] = enc_s(16, 7, 0);
        prog[19] = enc_s(20, 8, 0);
        prog[20] = enc_s(24, 9, 0);
        prog[21] = enc_s(28, 12, 0);
        prog[22] = enc_s(32, 13, 0);
        prog[23] = enc_s(36, 14, 0);
        // load followed at once by its use
        prog[24] = enc_i(8, 0, 2, 15, OP_LOAD);
        prog[25] = enc_i(1, 15, 0, 16, OP_IMM);
        prog[26] = enc_s(40, 16, 0);
        prog[27] = enc_i(128, 0, 2, 17, OP_LOAD);
        prog[28] = enc_s(44, 17, 0);
        // stores after taken branches and jumps are wrong-path
        prog[29] = enc_b(8, 1, 1, 0);
        prog[30] = enc_s(48, 1, 0);
        prog[31] = enc_b(8, 1, 1, 1);
        prog[32] = enc_s(52, 2, 0);
        prog[33] = enc_b(8, 1, 2, 4);
        prog[34] = enc_s(56, 2, 0);
        prog[35] = enc_b(8, 1, 2, 6);
        prog[36] = enc_j(8, 18);
        prog[37] = enc_s(60, 1, 0);
        prog[38] = enc_s(60, 18, 0);
        prog[39] = enc_u(0, 19, OP_AUIPC);
        prog[40] = enc_i(12, 19, 0, 20, OP_JALR);
        prog[41] = enc_s(64, 1, 0);
        prog[42] = enc_s(64, 20, 0);
        prog[43] = enc_b(8, 2, 1, 5);
        prog[44] = enc_s(68, 1, 0);
        prog[45] = enc_b(8, 2, 1, 7);
        prog[46] = enc_s(68, 19, 0);
        prog[47] = enc_j(0, 0);
    endfunction

    function automatic word_t alu(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // ISA-level run of the program, one instruction per step
    function automatic void run_model();
        word_t     x [32];
        word_t     m [64];
        word_t     pc;
        word_t     next_pc;
        word_t     inst;
        word_t     a;
        word_t     b;
        word_t     imm_i;
        word_t     addr;
        logic [2:0] f3;
        reg_addr_t rd;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            m[i] = fill_word(word_t'(i * 4));
        end
        pc = '0;
        for (int step = 0; step < 1000; step++) begin
            inst    = prog[pc[7:2]];
            f3      = inst[14:12];
            rd      = inst[11:7];
            a       = x[inst[19:15]];
            b       = x[inst[24:20]];
            imm_i   = {{20{inst[31]}}, inst[31:20]};
            next_pc = pc + 32'd4;
            case (inst[6:0])
                OP_LUI:   x[rd] = {inst[31:12], 12'b0};
                OP_AUIPC: x[rd] = pc + {inst[31:12], 12'b0};
                OP_JAL: begin
                    x[rd]   = pc + 32'd4;
                    next_pc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                    inst[30:21], 1'b0};
                end
                OP_JALR: begin
                    x[rd]   = pc + 32'd4;
                    next_pc = (a + imm_i) & ~32'd1;
                end
                OP_BRANCH: begin
                    if (branch_taken(f3, a, b)) begin
                        next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                        inst[11:8], 1'b0};
                    end
                end
                OP_LOAD: begin
                    addr  = a + imm_i;
                    x[rd] = m[addr[7:2]];
                end
                OP_STORE: begin
                    addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                    m[addr[7:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                OP_IMM:  x[rd] = alu(f3, inst[30] && f3 == 3'd5, a, imm_i);
                OP_REG:  x[rd] = alu(f3, inst[30], a, b);
                default: ;
            endcase
            x[0] = '0;
            // jump to itself ends the program
            if (next_pc == pc) begin
                break;
            end
            pc = next_pc;
        end
    endfunction

    task automatic check_ports_low(input bit with_inst);
        if (with_inst) begin
            assert (inst_rden == 1'b0) else begin
                $display("Error: inst_rden = %h, expected 0", inst_rden);
                errors++;
            end
        end
        assert (data_rden == 1'b0) else begin
            $display("Error: data_rden = %h, expected 0", data_rden);
            errors++;
        end
        assert (data_wren == 1'b0) else begin
            $display("Error: data_wren = %h, expected 0", data_wren);
            errors++;
        end
    endtask

    // both memories answer after 0-3 cycles and echo the address
    always @(negedge clk) begin
        mem_wait    = ($random(seed) & 7) == 0;
        inst_rvalid = 1'b0;
        data_rvalid = 1'b0;
        if (data_wren === 1'b1) begin
            dmem[data_waddr[7:2]] = data_wdata;
        end
        if (inst_rden !== 1'b1) begin
            i_busy = 1'b0;
        end else begin
            if (!i_busy || inst_riaddr != i_addr) begin
                i_busy  = 1'b1;
                i_addr  = inst_riaddr;
                i_delay = $random(seed) & 3;
            end
            if (i_delay == 0) begin
                inst_rvalid = 1'b1;
                inst_roaddr = i_addr;
                inst_rdata  = prog[i_addr[7:2]];
                i_busy      = 1'b0;
            end else begin
                i_delay--;
            end
        end
        if (data_rden !== 1'b1) begin
            d_busy = 1'b0;
        end else begin
            if (!d_busy || data_riaddr != d_addr) begin
                d_busy  = 1'b1;
                d_addr  = data_riaddr;
                d_delay = $random(seed) & 3;
            end
            if (d_delay == 0) begin
                data_rvalid = 1'b1;
                data_roaddr = d_addr;
                data_rdata  = dmem[d_addr[7:2]];
                d_busy      = 1'b0;
            end else begin
                d_delay--;
            end
        end
    end

    always @(negedge clk) begin
        if (data_wren === 1'b1) begin
            assert (exp_addr.size() > 0) else begin
                $display("store to %h seen after the last expected store", data_waddr);
                errors++;
            end
            if (exp_addr.size() > 0) begin
                exp_a = exp_addr.pop_front();
                exp_d = exp_data.pop_front();
                checked++;
                assert (data_waddr == exp_a) else begin
                    $display("Error: data_waddr = %h, expected %h", data_waddr, exp_a);
                    errors++;
                end
                assert (data_wdata == exp_d) else begin
                    $display("Error: data_wdata = %h, expected %h", data_wdata, exp_d);
                    errors++;
                end
            end
        end
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        inst_roaddr = '0;
        inst_rvalid = 1'b0;
        inst_rdata  = '0;
        data_roaddr = '0;
        data_rvalid = 1'b0;
        data_rdata  = '0;
        mem_wait    = 1'b0;
        i_busy      = 1'b0;
        d_busy      = 1'b0;
        errors      = 0;
        checked     = 0;
        cycles      = 0;
        load_program();
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fill_word(word_t'(i * 4));
        end
        run_model();

        repeat (10) begin
            @(negedge clk);
            check_ports_low(1'b1);
        end
        rst_n = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_ports_low(1'b0);
        end

        while (exp_addr.size() > 0 && cycles < TIMEOUT) begin
            @(negedge clk);
        end
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles with %0d stores still expected",
                     cycles, exp_addr.size());
            errors++;
        end else begin
            // extra stores after the last one would be wrong-path
            repeat (50) @(negedge clk);
        end
        $display("%0d stores checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/core.sv */
`timescale 1ns/1ps
`default_nettype none

module core #(
    parameter core_pkg::word_t reset_pc = 32'h0
) (
    input  wire                  clk,
    input  wire                  rst_n,

    output logic                 inst_rden,
    output core_pkg::word_t      inst_riaddr,
    input  wire core_pkg::word_t inst_roaddr,
    input  wire                  inst_rvalid,
    input  wire core_pkg::word_t inst_rdata,

    output logic                 data_rden,
    output core_pkg::word_t      data_riaddr,
    input  wire core_pkg::word_t data_roaddr,
    input  wire                  data_rvalid,
    input  wire core_pkg::word_t data_rdata,
    output logic                 data_wren,
    output core_pkg::word_t      data_waddr,
    output core_pkg::word_t      data_wdata,

    input  wire                  mem_wait
);
    import core_pkg::*;

    // pipeline control
    wire logic  flush;
    wire logic  hold;
    wire word_t new_pc;

    // fetch to decode
    wire logic  inst_valid;
    wire logic  inst_ready;
    wire word_t inst_pc;
    wire word_t inst_data;

    // register read and write-back
    wire reg_addr_t rs1_addr;
    wire reg_addr_t rs2_addr;
    wire word_t     rs1_data;
    wire word_t     rs2_data;
    wire logic      operands_ready;
    wire logic      wb_en;
    wire reg_addr_t wb_rd;
    wire word_t     wb_data;

    decode_bus_if dbus ();
    exec_bus_if   xbus ();

    fetch #(
        .reset_pc (reset_pc)
    ) u_fetch (.*);

    decode u_decode (.*);

    rv32i_reg u_rv32i_reg (
        .fwd (xbus),
        .*
    );

    exec u_exec (.*);

    mem_access u_mem_access (.*);

endmodule

`default_nettype wire

/* hdl/mem_access.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_access (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  mem_wait,
    output logic                 hold,
    exec_bus_if.dst              xbus,
    output logic                 data_rden,
    output core_pkg::word_t      data_riaddr,
    input  wire core_pkg::word_t data_roaddr,
    input  wire                  data_rvalid,
    input  wire core_pkg::word_t data_rdata,
    output logic                 data_wren,
    output core_pkg::word_t      data_waddr,
    output core_pkg::word_t      data_wdata,
    output logic                 wb_en,
    output core_pkg::reg_addr_t  wb_rd,
    output core_pkg::word_t      wb_data
);
    import core_pkg::*;

    mem_state_e state;
    logic       take;
    logic       resp_hit;
    logic       load_wb;

    // the whole pipeline behind us freezes while a load is out
    assign hold     = mem_wait || state == WAIT_DATA;
    assign take     = state == READY && xbus.valid && !mem_wait;
    assign resp_hit = state == WAIT_DATA && data_rvalid && data_roaddr == data_riaddr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= READY;
            data_rden <= 1'b0;
            data_wren <= 1'b0;
            wb_en     <= 1'b0;
        end else begin
            data_wren <= take && xbus.is_store;
            wb_en     <= (take && !xbus.is_load && xbus.rd_en) || (resp_hit && load_wb);
            if (take && xbus.is_load) begin
                state     <= WAIT_DATA;
                data_rden <= 1'b1;
            end else if (resp_hit) begin
                state     <= READY;
                data_rden <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            data_riaddr <= xbus.result;
            data_waddr  <= xbus.result;
            data_wdata  <= xbus.store_data;
            wb_rd       <= xbus.rd;
            wb_data     <= xbus.result;
            load_wb     <= xbus.rd_en;
        end else if (resp_hit) begin
            wb_data <= data_rdata;
        end
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_rden && data_wren));

endmodule

`default_nettype wire

/* hdl/exec.sv */
`timescale 1ns/1ps
`default_nettype none

module exec (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             hold,
    decode_bus_if.dst       dbus,
    exec_bus_if.src         xbus,
    output logic            flush,
    output core_pkg::word_t new_pc
);
    import core_pkg::*;

    word_t op_b;
    word_t alu_out;
    word_t target;
    word_t result;
    logic  cond;
    logic  taken;

    assign op_b = dbus.use_imm ? dbus.imm : dbus.rs2_data;

    always_comb begin
        case (dbus.alu_op)
            ALU_SUB:  alu_out = dbus.rs1_data - op_b;
            ALU_SLL:  alu_out = dbus.rs1_data << op_b[4:0];
            ALU_SLT:  alu_out = {31'b0, $signed(dbus.rs1_data) < $signed(op_b)};
            ALU_SLTU: alu_out = {31'b0, dbus.rs1_data < op_b};
            ALU_XOR:  alu_out = dbus.rs1_data ^ op_b;
            ALU_SRL:  alu_out = dbus.rs1_data >> op_b[4:0];
            ALU_SRA:  alu_out = word_t'($signed(dbus.rs1_data) >>> op_b[4:0]);
            ALU_OR:   alu_out = dbus.rs1_data | op_b;
            ALU_AND:  alu_out = dbus.rs1_data & op_b;
            default:  alu_out = dbus.rs1_data + op_b;
        endcase
    end

    always_comb begin
        case (dbus.funct3)
            3'b000:  cond = dbus.rs1_data == dbus.rs2_data;
            3'b001:  cond = dbus.rs1_data != dbus.rs2_data;
            3'b100:  cond = $signed(dbus.rs1_data) < $signed(dbus.rs2_data);
            3'b101:  cond = $signed(dbus.rs1_data) >= $signed(dbus.rs2_data);
            3'b110:  cond = dbus.rs1_data < dbus.rs2_data;
            3'b111:  cond = dbus.rs1_data >= dbus.rs2_data;
            default: cond = 1'b0;
        endcase
    end

    assign target = dbus.is_jalr ? (alu_out & ~32'd1) : dbus.pc + dbus.imm;

    always_comb begin
        if (dbus.is_jal || dbus.is_jalr) begin
            result = dbus.pc + 32'd4;
        end else if (dbus.is_lui) begin
            result = dbus.imm;
        end else if (dbus.is_auipc) begin
            result = dbus.pc + dbus.imm;
        end else begin
            result = alu_out;
        end
    end

    // item seen during flush is wrong-path
    assign taken = dbus.valid && !flush &&
                   (dbus.is_jal || dbus.is_jalr || (dbus.is_branch && cond));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            xbus.valid <= 1'b0;
            flush      <= 1'b0;
        end else if (hold) begin
            flush <= 1'b0;
        end else begin
            xbus.valid <= dbus.valid && !flush;
            flush      <= taken;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            xbus.rd         <= dbus.rd;
            xbus.rd_en      <= dbus.rd_en;
            xbus.result     <= result;
            xbus.is_load    <= dbus.is_load;
            xbus.is_store   <= dbus.is_store;
            xbus.store_data <= dbus.rs2_data;
            new_pc          <= target;
        end
    end

    // fetch has no misaligned path
    a_target_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        flush |-> new_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* hdl/rv32i_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32i_reg (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire core_pkg::reg_addr_t rs1_addr,
    input  wire core_pkg::reg_addr_t rs2_addr,
    output core_pkg::word_t          rs1_data,
    output core_pkg::word_t          rs2_data,
    output logic                     operands_ready,
    exec_bus_if.fwd                  fwd,
    input  wire                      wb_en,
    input  wire core_pkg::reg_addr_t wb_rd,
    input  wire core_pkg::word_t     wb_data
);
    import core_pkg::*;

    word_t regs [32];

    // exec result before write-back before the array
    function automatic word_t read_src(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (fwd.valid && fwd.rd_en && !fwd.is_load && fwd.rd == addr) begin
            return fwd.result;
        end
        if (wb_en && wb_rd == addr) begin
            return wb_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_src(rs1_addr);
        rs2_data = read_src(rs2_addr);
    end

    // load data not back yet
    assign operands_ready = !(fwd.valid && fwd.is_load && fwd.rd_en &&
                              (fwd.rd == rs1_addr || fwd.rd == rs2_addr));

    always_ff @(posedge clk) begin
        if (wb_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // decode clears rd_en for x0 so write-back never targets it
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en |-> wb_rd != '0);

endmodule

`default_nettype wire

/* hdl/decode.sv */
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  flush,
    input  wire                  hold,
    input  wire                  inst_valid,
    input  wire core_pkg::word_t inst_pc,
    input  wire core_pkg::word_t inst_data,
    output logic                 inst_ready,
    output core_pkg::reg_addr_t  rs1_addr,
    output core_pkg::reg_addr_t  rs2_addr,
    input  wire core_pkg::word_t rs1_data,
    input  wire core_pkg::word_t rs2_data,
    input  wire                  operands_ready,
    decode_bus_if.src            dbus
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic       alt;
    logic       writes_rd;
    logic       raw_hazard;
    word_t      imm;
    alu_op_t    alu_op;

    assign opcode   = inst_data[6:0];
    assign funct3   = inst_data[14:12];
    assign rd       = inst_data[11:7];
    assign rs1_addr = inst_data[19:15];
    assign rs2_addr = inst_data[24:20];

    always_comb begin
        case (opcode)
            OP_STORE:  imm = {{20{inst_data[31]}}, inst_data[31:25], inst_data[11:7]};
            OP_BRANCH: imm = {{19{inst_data[31]}}, inst_data[31], inst_data[7],
                              inst_data[30:25], inst_data[11:8], 1'b0};
            OP_LUI,
            OP_AUIPC:  imm = {inst_data[31:12], 12'b0};
            OP_JAL:    imm = {{11{inst_data[31]}}, inst_data[31], inst_data[19:12],
                              inst_data[20], inst_data[30:21], 1'b0};
            default:   imm = {{20{inst_data[31]}}, inst_data[31:20]};
        endcase
    end

    // funct7[5] picks sub or sra and op-imm uses it only on shifts
    assign alt    = inst_data[30] && (opcode == OP_REG || funct3 == 3'b101);
    assign alu_op = (opcode == OP_REG || opcode == OP_IMM) ? alu_op_t'({alt, funct3})
                                                           : ALU_ADD;

    assign writes_rd = opcode inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD,
                                      OP_IMM, OP_REG};

    // result of the item now in exec is not forwardable yet
    assign raw_hazard = dbus.valid && dbus.rd_en &&
                        (dbus.rd == rs1_addr || dbus.rd == rs2_addr);
    assign inst_ready = !hold && operands_ready && !raw_hazard;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            dbus.valid <= 1'b0;
        end else if (!hold) begin
            // bubble when nothing transfers
            dbus.valid <= inst_valid && inst_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_ready) begin
            dbus.pc        <= inst_pc;
            dbus.rd        <= rd;
            dbus.rd_en     <= writes_rd && rd != '0;
            dbus.rs1_data  <= rs1_data;
            dbus.rs2_data  <= rs2_data;
            dbus.imm       <= imm;
            dbus.alu_op    <= alu_op;
            dbus.use_imm   <= opcode != OP_REG;
            dbus.is_branch <= opcode == OP_BRANCH;
            dbus.funct3    <= funct3;
            dbus.is_jal    <= opcode == OP_JAL;
            dbus.is_jalr   <= opcode == OP_JALR;
            dbus.is_load   <= opcode == OP_LOAD;
            dbus.is_store  <= opcode == OP_STORE;
            dbus.is_lui    <= opcode == OP_LUI;
            dbus.is_auipc  <= opcode == OP_AUIPC;
        end
    end

endmodule

`default_nettype wire

/* hdl/fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch #(
    parameter core_pkg::word_t reset_pc = '0
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  flush,
    input  wire core_pkg::word_t new_pc,
    output logic                 inst_rden,
    output core_pkg::word_t      inst_riaddr,
    input  wire core_pkg::word_t inst_roaddr,
    input  wire                  inst_rvalid,
    input  wire core_pkg::word_t inst_rdata,
    output logic                 inst_valid,
    output core_pkg::word_t      inst_pc,
    output core_pkg::word_t      inst_data,
    input  wire                  inst_ready
);
    import core_pkg::*;

    fetch_state_e state;
    word_t        pc;
    logic         resp_hit;

    assign inst_rden   = state == WAIT_INST;
    assign inst_riaddr = pc;
    assign inst_valid  = state == HAVE_INST;
    assign inst_pc     = pc;

    // responses for any other address are stale
    assign resp_hit = inst_rden && inst_rvalid && inst_roaddr == pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            pc    <= reset_pc;
        end else if (flush) begin
            state <= WAIT_INST;
            pc    <= new_pc;
        end else begin
            case (state)
                IDLE:      state <= WAIT_INST;
                WAIT_INST: if (resp_hit) state <= HAVE_INST;
                HAVE_INST: begin
                    if (inst_ready) begin
                        state <= WAIT_INST;
                        pc    <= pc + 32'd4;
                    end
                end
                default:   state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (resp_hit) begin
            inst_data <= inst_rdata;
        end
    end

    // no compressed encodings
    a_full_width_inst: assert property (@(posedge clk) disable iff (!rst_n)
        resp_hit |-> inst_rdata[1:0] == 2'b11);

endmodule

`default_nettype wire

/* hdl/stage_if.sv */
`timescale 1ns/1ps
`default_nettype none

// decoded instruction from decode to exec
interface decode_bus_if;
    import core_pkg::*;

    logic       valid;
    word_t      pc;
    reg_addr_t  rd;
    logic       rd_en;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    alu_op_t    alu_op;
    logic       use_imm;
    logic       is_branch;
    logic [2:0] funct3;
    logic       is_jal;
    logic       is_jalr;
    logic       is_load;
    logic       is_store;
    logic       is_lui;
    logic       is_auipc;

    modport src (output valid, pc, rd, rd_en, rs1_data, rs2_data, imm, alu_op, use_imm,
                 is_branch, funct3, is_jal, is_jalr, is_load, is_store, is_lui, is_auipc);
    modport dst (input valid, pc, rd, rd_en, rs1_data, rs2_data, imm, alu_op, use_imm,
                 is_branch, funct3, is_jal, is_jalr, is_load, is_store, is_lui, is_auipc);
endinterface

// executed result from exec to mem_access
interface exec_bus_if;
    import core_pkg::*;

    logic      valid;
    reg_addr_t rd;
    logic      rd_en;
    word_t     result;
    logic      is_load;
    logic      is_store;
    word_t     store_data;

    modport src (output valid, rd, rd_en, result, is_load, is_store, store_data);
    modport dst (input valid, rd, rd_en, result, is_load, is_store, store_data);
    modport fwd (input valid, rd, rd_en, result, is_load);
endinterface

`default_nettype wire

/* hdl/core_pkg.sv */
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;

    // {funct7[5], funct3} so decode can build the code directly
    localparam alu_op_t ALU_ADD  = 4'b0000;
    localparam alu_op_t ALU_SUB  = 4'b1000;
    localparam alu_op_t ALU_SLL  = 4'b0001;
    localparam alu_op_t ALU_SLT  = 4'b0010;
    localparam alu_op_t ALU_SLTU = 4'b0011;
    localparam alu_op_t ALU_XOR  = 4'b0100;
    localparam alu_op_t ALU_SRL  = 4'b0101;
    localparam alu_op_t ALU_SRA  = 4'b1101;
    localparam alu_op_t ALU_OR   = 4'b0110;
    localparam alu_op_t ALU_AND  = 4'b0111;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_INST,
        HAVE_INST
    } fetch_state_e;

    typedef enum logic {
        READY,
        WAIT_DATA
    } mem_state_e;

endpackage

`default_nettype wire
